//--- common/notchPkg.sv
// shared widths, tap and register address enums, default biquad coefficients
`default_nettype none

package notchPkg;

	// datapath widths, used as defaults for the top-level parameters
	localparam int SampleWidth   = 32; // x and y words
	localparam int CoeffWidth    = 16; // signed coefficient
	localparam int CoeffFracBits = 14; // Q2.14, sets the output shift

	// a biquad always has five products
	localparam int NumTaps = 5;

	// product order, shared by coefficient, operand and product arrays
	typedef enum logic [2:0] {
		tapB0 = 3'd0, // b0 * x(n)
		tapB1 = 3'd1, // b1 * x(n-1)
		tapB2 = 3'd2, // b2 * x(n-2)
		tapA1 = 3'd3, // a1 * y(n-1), subtracted
		tapA2 = 3'd4  // a2 * y(n-2), subtracted
	} tapIndexE;

	// register port map
	typedef enum logic [3:0] {
		regCtrl  = 4'd0, // bit0 passThrough, bit1 clear (self-clearing)
		regB0    = 4'd1,
		regB1    = 4'd2,
		regB2    = 4'd3,
		regA1    = 4'd4,
		regA2    = 4'd5,
		regCount = 4'd6  // read only, results produced
	} regAddrE;

	// notch at a fixed normalized frequency, coefficients scaled by 2^14
	// a = 1 -1.894 0.914, b = 0.505 -1 0.505
	localparam logic signed [15:0] DefaultB0 = 16'sd8275;
	localparam logic signed [15:0] DefaultB1 = -16'sd16383;
	localparam logic signed [15:0] DefaultB2 = 16'sd8275;
	localparam logic signed [15:0] DefaultA1 = -16'sd31035;
	localparam logic signed [15:0] DefaultA2 = 16'sd14969;

endpackage

`default_nettype wire

//--- biquad/tapMultiplier.sv
// one registered signed operand times coefficient product with valid flag
`timescale 1ns/1ps
`default_nettype none

module tapMultiplier #(
	parameter int SampleWidth = notchPkg::SampleWidth,
	parameter int CoeffWidth  = notchPkg::CoeffWidth,
	localparam int ProductWidth = SampleWidth + CoeffWidth
) (
	input  wire logic                          clk,
	input  wire logic                          rstN,
	input  wire logic signed [SampleWidth-1:0] operand,
	input  wire logic signed [CoeffWidth-1:0]  coeff,
	input  wire logic                          opValid,
	output logic signed [ProductWidth-1:0]     product,
	output logic                               productValid
);

	// full-width product, no rounding here
	always_ff @(posedge clk) begin
		if (opValid)
			product <= operand * coeff; // both signed, extended to ProductWidth
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			productValid <= 1'b0;
		else
			productValid <= opValid; // product ready at T+1
	end

endmodule

`default_nettype wire

//--- biquad/sampleHistory.sv
// sample acceptance, busy level, x and y delay lines, tap operand registers
`timescale 1ns/1ps
`default_nettype none

module sampleHistory #(
	parameter int SampleWidth = notchPkg::SampleWidth
) (
	input  wire logic                          clk,
	input  wire logic                          rstN,
	input  wire logic                          sampleValid,
	input  wire logic signed [SampleWidth-1:0] sample,
	input  wire logic                          clear,
	input  wire logic signed [SampleWidth-1:0] yNew,
	input  wire logic                          resultValid,
	output logic signed [SampleWidth-1:0]      operands [notchPkg::NumTaps],
	output logic signed [SampleWidth-1:0]      xNow,
	output logic                               opValid,
	output logic                               busy
);
	import notchPkg::*;

	logic signed [SampleWidth-1:0] xPrev1; // x(n-1)
	logic signed [SampleWidth-1:0] xPrev2; // x(n-2)
	logic signed [SampleWidth-1:0] yPrev1; // y(n-1)
	logic signed [SampleWidth-1:0] yPrev2; // y(n-2)
	logic signed [SampleWidth-1:0] yFwd1;  // y history as seen after this edge
	logic signed [SampleWidth-1:0] yFwd2;
	logic                          inFlight;
	logic                          accept;

	// busy drops while the result is on the port, so the next sample lands at T+3
	assign busy   = inFlight && !resultValid;
	assign accept = sampleValid && !busy;
	assign yFwd1  = resultValid ? yNew : yPrev1; // forward y(n) not yet shifted in
	assign yFwd2  = resultValid ? yPrev1 : yPrev2;

	// delay lines, clear wins over a pending shift
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			xPrev1 <= '0;
			xPrev2 <= '0;
			yPrev1 <= '0;
			yPrev2 <= '0;
		end else begin
			if (accept) begin
				xPrev1 <= sample;
				xPrev2 <= xPrev1;
			end
			if (resultValid) begin
				yPrev1 <= yNew;
				yPrev2 <= yPrev1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			inFlight <= 1'b0;
			opValid  <= 1'b0;
		end else begin
			opValid <= accept; // one-cycle strobe to the multipliers
			if (resultValid)
				inFlight <= 1'b0;
			if (accept)
				inFlight <= 1'b1;
		end
	end

	// operand snapshot in tap order
	always_ff @(posedge clk) begin
		if (accept) begin
			operands[tapB0] <= sample;
			operands[tapB1] <= xPrev1;
			operands[tapB2] <= xPrev2;
			operands[tapA1] <= yFwd1;
			operands[tapA2] <= yFwd2;
			xNow            <= sample;
		end
	end

	// a strobe during a computation must not start the multipliers
	assert property (@(posedge clk) disable iff (!rstN) sampleValid && busy |=> !opValid)
		else $error("sample accepted while busy");

endmodule

`default_nettype wire

//--- biquad/filterAccumulator.sv
// signed sum of the five tap products, Q14 shift, saturation and result registers
`timescale 1ns/1ps
`default_nettype none

module filterAccumulator #(
	parameter int SampleWidth   = notchPkg::SampleWidth,
	parameter int CoeffWidth    = notchPkg::CoeffWidth,
	parameter int CoeffFracBits = notchPkg::CoeffFracBits,
	localparam int ProductWidth = SampleWidth + CoeffWidth,
	localparam int SumWidth     = ProductWidth + 3
) (
	input  wire logic                           clk,
	input  wire logic                           rstN,
	input  wire logic signed [ProductWidth-1:0] products [notchPkg::NumTaps],
	input  wire logic [notchPkg::NumTaps-1:0]   productValid,
	input  wire logic signed [SampleWidth-1:0]  xNow,
	input  wire logic                           passThrough,
	output logic signed [SampleWidth-1:0]       yNew,
	output logic signed [SampleWidth-1:0]       result,
	output logic                                resultValid
);
	import notchPkg::*;

	localparam logic signed [SampleWidth-1:0] MaxSample = {1'b0, {(SampleWidth-1){1'b1}}};
	localparam logic signed [SampleWidth-1:0] MinSample = {1'b1, {(SampleWidth-1){1'b0}}};

	logic signed [SumWidth-1:0]    sum;     // full width, 3 guard bits
	logic signed [SumWidth-1:0]    shifted; // scaled back to sample units
	logic signed [SampleWidth-1:0] ySat;
	logic                          allValid;

	assign allValid = &productValid; // multipliers run in lockstep

	// b products add, a products subtract
	always_comb begin
		sum = '0;
		for (int i = 0; i < NumTaps; i++) begin
			if (tapIndexE'(i) inside {tapA1, tapA2})
				sum = sum - SumWidth'(products[i]);
			else
				sum = sum + SumWidth'(products[i]);
		end
	end

	assign shifted = sum >>> CoeffFracBits; // arithmetic, rounds toward -inf

	// clamp to the signed sample range
	always_comb begin
		if (shifted > MaxSample)
			ySat = MaxSample;
		else if (shifted < MinSample)
			ySat = MinSample;
		else
			ySat = shifted[SampleWidth-1:0];
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			resultValid <= 1'b0;
		else
			resultValid <= allValid; // strobe at T+2
	end

	always_ff @(posedge clk) begin
		if (allValid) begin
			yNew   <= ySat;                         // filter state always advances
			result <= passThrough ? xNow : ySat;
		end
	end

	// the five tap flags come from one opValid strobe
	assert property (@(posedge clk) disable iff (!rstN)
		(productValid == '0) || (productValid == '1))
		else $error("tap multipliers out of step");

	// exactly one result per product set, one cycle later
	assert property (@(posedge clk) disable iff (!rstN)
		resultValid == $past(productValid[tapB0]))
		else $error("resultValid not aligned to products");

endmodule

`default_nettype wire

//--- verilog/filterRegs.sv
// coefficient and control registers, registered read mux, result counter
`timescale 1ns/1ps
`default_nettype none

module filterRegs #(
	parameter int CoeffWidth = notchPkg::CoeffWidth
) (
	input  wire logic                         clk,
	input  wire logic                         rstN,
	input  wire logic                         regWrite,
	input  wire logic                         regRead,
	input  wire notchPkg::regAddrE            regAddr,
	input  wire logic [31:0]                  regWriteData,
	output logic [31:0]                       regReadData,
	input  wire logic                         resultValid,
	output logic signed [CoeffWidth-1:0]      coeffs [notchPkg::NumTaps],
	output logic                              passThrough,
	output logic                              clear
);
	import notchPkg::*;

	logic [31:0] resultCount; // results produced since reset
	logic        ctrlWrite;

	assign ctrlWrite = regWrite && (regAddr == regCtrl);

	// coefficients, reset to the notch defaults
	always_ff @(posedge clk) begin
		if (!rstN) begin
			coeffs[tapB0] <= CoeffWidth'(DefaultB0);
			coeffs[tapB1] <= CoeffWidth'(DefaultB1);
			coeffs[tapB2] <= CoeffWidth'(DefaultB2);
			coeffs[tapA1] <= CoeffWidth'(DefaultA1);
			coeffs[tapA2] <= CoeffWidth'(DefaultA2);
		end else if (regWrite) begin
			case (regAddr)
				regB0:   coeffs[tapB0] <= regWriteData[CoeffWidth-1:0];
				regB1:   coeffs[tapB1] <= regWriteData[CoeffWidth-1:0];
				regB2:   coeffs[tapB2] <= regWriteData[CoeffWidth-1:0];
				regA1:   coeffs[tapA1] <= regWriteData[CoeffWidth-1:0];
				regA2:   coeffs[tapA2] <= regWriteData[CoeffWidth-1:0];
				default: ; // ctrl handled below, count is read only
			endcase
		end
	end

	// control bits
	always_ff @(posedge clk) begin
		if (!rstN) begin
			passThrough <= 1'b0;
			clear       <= 1'b0;
		end else begin
			if (ctrlWrite)
				passThrough <= regWriteData[0];
			clear <= ctrlWrite && regWriteData[1] && !clear; // single-cycle pulse
		end
	end

	// count of results leaving the datapath
	always_ff @(posedge clk) begin
		if (!rstN)
			resultCount <= '0;
		else if (resultValid)
			resultCount <= resultCount + 32'd1;
	end

	// read data one cycle after regRead, coefficients sign-extended
	always_ff @(posedge clk) begin
		if (regRead) begin
			case (regAddr)
				regCtrl:  regReadData <= {31'd0, passThrough}; // clear always reads 0
				regB0:    regReadData <= 32'(coeffs[tapB0]);
				regB1:    regReadData <= 32'(coeffs[tapB1]);
				regB2:    regReadData <= 32'(coeffs[tapB2]);
				regA1:    regReadData <= 32'(coeffs[tapA1]);
				regA2:    regReadData <= 32'(coeffs[tapA2]);
				regCount: regReadData <= resultCount;
				default:  regReadData <= '0;
			endcase
		end
	end

	// history clear must stay a single pulse, even for back-to-back writes
	assert property (@(posedge clk) disable iff (!rstN) clear |=> !clear)
		else $error("clear held for two cycles");

endmodule

`default_nettype wire

//--- verilog/notchFilter.sv
// notch filter top level: register block, sample history, tap multipliers, accumulator
`timescale 1ns/1ps
`default_nettype none

module notchFilter #(
	parameter int SampleWidth   = notchPkg::SampleWidth,
	parameter int CoeffWidth    = notchPkg::CoeffWidth,
	parameter int CoeffFracBits = notchPkg::CoeffFracBits,
	localparam int ProductWidth = SampleWidth + CoeffWidth
) (
	input  wire logic                          clk,
	input  wire logic                          rstN,
	input  wire logic                          regWrite,
	input  wire logic                          regRead,
	input  wire notchPkg::regAddrE             regAddr,
	input  wire logic [31:0]                   regWriteData,
	output logic [31:0]                        regReadData,
	input  wire logic                          sampleValid,
	input  wire logic signed [SampleWidth-1:0] sample,
	output logic                               busy,
	output logic                               resultValid,
	output logic signed [SampleWidth-1:0]      result
);
	import notchPkg::*;

	logic signed [CoeffWidth-1:0]   coeffs [NumTaps];   // tap order
	logic signed [SampleWidth-1:0]  operands [NumTaps]; // x(n)..y(n-2)
	logic signed [ProductWidth-1:0] products [NumTaps];
	logic [NumTaps-1:0]             productValid;       // one flag per multiplier
	logic signed [SampleWidth-1:0]  xNow;               // accepted sample, for pass-through
	logic signed [SampleWidth-1:0]  yNew;               // filter output fed back
	logic                           opValid;
	logic                           passThrough;
	logic                           clear;

	filterRegs #(.CoeffWidth(CoeffWidth)) i_filterRegs (
		.clk, .rstN,
		.regWrite, .regRead, .regAddr, .regWriteData, .regReadData,
		.resultValid,
		.coeffs, .passThrough, .clear
	);

	sampleHistory #(.SampleWidth(SampleWidth)) i_sampleHistory (
		.clk, .rstN,
		.sampleValid, .sample, .clear,
		.yNew, .resultValid,
		.operands, .xNow, .opValid, .busy
	);

	// one registered product per tap
	for (genvar i = 0; i < NumTaps; i++) begin : gTap
		tapMultiplier #(
			.SampleWidth(SampleWidth),
			.CoeffWidth(CoeffWidth)
		) i_tapMultiplier (
			.clk, .rstN,
			.operand(operands[i]),
			.coeff(coeffs[i]),
			.opValid,
			.product(products[i]),
			.productValid(productValid[i])
		);
	end

	filterAccumulator #(
		.SampleWidth(SampleWidth),
		.CoeffWidth(CoeffWidth),
		.CoeffFracBits(CoeffFracBits)
	) i_filterAccumulator (
		.clk, .rstN,
		.products, .productValid, .xNow, .passThrough,
		.yNew, .result, .resultValid
	);

endmodule

`default_nettype wire

//--- bench/clockGen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int Period      = 20, // ns
	parameter int ResetCycles = 4
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	// reset spans ResetCycles rising edges, released on a falling edge
	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/notchFilterTb.sv
// notch filter testbench: stimulus table, biquad reference model, checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module notchFilterTb;
	import notchPkg::*;

	typedef enum logic [2:0] {opWrite, opRead, opSample, opSampleBusy, opClear} tableOpE;

	localparam longint SatMax = 64'sd2147483647;
	localparam longint SatMin = -64'sd2147483648;

	logic clk;
	logic rstN;
	logic regWrite;
	logic regRead;
	regAddrE regAddr;
	logic [31:0] regWriteData;
	logic [31:0] regReadData;
	logic sampleValid;
	logic signed [31:0] sample;
	logic busy;
	logic resultValid;
	logic signed [31:0] result;

	tableOpE opQ [$]; // stimulus table, one column per queue
	regAddrE addrQ [$];
	logic [31:0] dataQ [$];
	longint expectQ [$];
	int plannedResults = 0; // samples the table expects to be accepted
	int pulseCount = 0;     // resultValid pulses seen on the port
	bit tableReady = 0;
	logic [31:0] lfsrState = 32'hb712_260a;

	// model state: own coefficient copy and history
	longint mB0 = 8275, mB1 = -16383, mB2 = 8275, mA1 = -31035, mA2 = 14969;
	longint mX1 = 0, mX2 = 0, mY1 = 0, mY2 = 0;
	bit mPass = 0;
	bit satHigh = 0; // model hit the positive limit
	bit satLow = 0;

	clockGen #(.Period(20), .ResetCycles(4)) i_clockGen (.clk, .rstN);

	notchFilter #(.SampleWidth(32), .CoeffWidth(16), .CoeffFracBits(14)) i_notchFilter (
		.clk, .rstN,
		.regWrite, .regRead, .regAddr, .regWriteData, .regReadData,
		.sampleValid, .sample,
		.busy, .resultValid, .result
	);

	always @(negedge clk) begin
		if (rstN && resultValid)
			pulseCount++; // one per result strobe
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1); // galois form
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] randomWord();
		logic [31:0] w;
		w = '0;
		for (int k = 0; k < 32; k++) begin
			w = {w[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return w;
	endfunction

	function automatic longint signExtend16(input logic [31:0] v);
		return longint'($signed(v[15:0]));
	endfunction

	// y = (b.x - a.y) >>> 14, saturated; history advances even in pass-through
	function automatic longint modelStep(input longint x);
		longint acc;
		longint y;
		acc = mB0 * x + mB1 * mX1 + mB2 * mX2 - mA1 * mY1 - mA2 * mY2;
		y = acc >>> 14; // rounds toward -inf like the hardware
		if (y > SatMax) begin
			y = SatMax;
			satHigh = 1;
		end else if (y < SatMin) begin
			y = SatMin;
			satLow = 1;
		end
		mX2 = mX1;
		mX1 = x;
		mY2 = mY1;
		mY1 = y;
		return mPass ? x : y;
	endfunction

	task automatic checkValue(input string name, input logic signed [63:0] expected,
			input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic addEntry(input tableOpE op, input regAddrE addr, input logic [31:0] data,
			input longint expected);
		opQ.push_back(op);
		addrQ.push_back(addr);
		dataQ.push_back(data);
		expectQ.push_back(expected);
		if (op == opSample || op == opSampleBusy)
			plannedResults++;
	endtask

	// coefficient writes in tap order, optional read-back
	task automatic addCoeffs(input int b0, input int b1, input int b2, input int a1,
			input int a2, input bit readBack);
		regAddrE addrs [5];
		int vals [5];
		int k;
		addrs = '{regB0, regB1, regB2, regA1, regA2};
		vals = '{b0, b1, b2, a1, a2};
		for (k = 0; k < 5; k++)
			addEntry(opWrite, addrs[k], vals[k], 0);
		if (readBack) begin
			for (k = 0; k < 5; k++)
				addEntry(opRead, addrs[k], 0, signExtend16(vals[k]));
		end
	endtask

	task automatic buildTable();
		int k;
		// defaults after reset
		addEntry(opRead, regB0, 0, 8275);
		addEntry(opRead, regB1, 0, -16383);
		addEntry(opRead, regB2, 0, 8275);
		addEntry(opRead, regA1, 0, -31035);
		addEntry(opRead, regA2, 0, 14969);
		addEntry(opRead, regCount, 0, 0);
		// impulse response
		addEntry(opSample, regCtrl, 32'd1_000_000, 0);
		for (k = 0; k < 11; k++)
			addEntry(opSample, regCtrl, 0, 0);
		// new coefficients, random samples
		addCoeffs(4096, -2000, 3000, -12000, 6000, 1);
		for (k = 0; k < 40; k++)
			addEntry(opSample, regCtrl, randomWord(), 0);
		// large gains with full-scale input hit both limits
		addCoeffs(32767, 32767, 32767, 16384, 0, 0);
		for (k = 0; k < 3; k++)
			addEntry(opSample, regCtrl, 32'h7fff_ffff, 0);
		for (k = 0; k < 3; k++)
			addEntry(opSample, regCtrl, 32'h8000_0000, 0);
		for (k = 0; k < 2; k++)
			addEntry(opSample, regCtrl, randomWord(), 0);
		addCoeffs(8275, -16383, 8275, -31035, 14969, 0);
		// pass-through, then back to filtering
		addEntry(opWrite, regCtrl, 32'h1, 0);
		for (k = 0; k < 6; k++)
			addEntry(opSample, regCtrl, randomWord() >>> 8, 0);
		addEntry(opWrite, regCtrl, 32'h0, 0);
		for (k = 0; k < 6; k++)
			addEntry(opSample, regCtrl, randomWord() >>> 8, 0);
		// strobes during busy are dropped
		for (k = 0; k < 4; k++)
			addEntry(opSampleBusy, regCtrl, randomWord() >>> 4, 0);
		addEntry(opSample, regCtrl, 32'd4242, 0);
		addEntry(opSample, regCtrl, -32'sd99, 0);
		addEntry(opRead, regCount, 0, plannedResults);
		// history clear
		addEntry(opClear, regCtrl, 32'h2, 0);
		addEntry(opSample, regCtrl, 32'd12345, 0);
		addEntry(opSample, regCtrl, -32'sd777, 0);
		addEntry(opRead, regCount, 0, plannedResults);
	endtask

	task automatic writeRegister(input regAddrE addr, input logic [31:0] data);
		regWrite = 1'b1;
		regAddr = addr;
		regWriteData = data;
		@(posedge clk);
		@(negedge clk);
		regWrite = 1'b0;
		case (addr) // mirror into the model
			regB0: mB0 = signExtend16(data);
			regB1: mB1 = signExtend16(data);
			regB2: mB2 = signExtend16(data);
			regA1: mA1 = signExtend16(data);
			regA2: mA2 = signExtend16(data);
			regCtrl: begin
				mPass = data[0];
				if (data[1]) begin
					mX1 = 0;
					mX2 = 0;
					mY1 = 0;
					mY2 = 0;
				end
			end
			default: ;
		endcase
		@(posedge clk); // clear pulse lands on this edge
		@(negedge clk);
	endtask

	task automatic readRegister(input regAddrE addr, input longint expected);
		@(posedge clk); // a result strobe from the edge before reaches the counter
		@(negedge clk);
		regRead = 1'b1;
		regAddr = addr;
		@(posedge clk);
		@(negedge clk);
		regRead = 1'b0;
		checkValue("regReadData", expected, $signed(regReadData));
		if (addr == regCount)
			checkValue("resultValid pulse count", expected, pulseCount);
	endtask

	// one accepted sample, optionally followed by a strobe while busy
	task automatic applySample(input logic [31:0] x, input bit strobeWhileBusy);
		longint expected;
		int edges;
		checkValue("busy", 0, busy);
		expected = modelStep(longint'($signed(x)));
		sampleValid = 1'b1;
		sample = x;
		@(posedge clk); // accepting edge
		@(negedge clk);
		if (strobeWhileBusy) begin
			checkValue("busy", 1, busy);
			sample = x ^ 32'h5a5a_5a5a; // must never reach the filter
		end else begin
			sampleValid = 1'b0;
		end
		edges = 0;
		do begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			sampleValid = 1'b0;
		end while (!resultValid && edges < 10);
		checkValue("resultValid latency", 2, edges);
		checkValue("result", expected, result); // next entry may start at T+3
	endtask

	initial begin
		regWrite = 1'b0;
		regRead = 1'b0;
		regAddr = regCtrl;
		regWriteData = '0;
		sampleValid = 1'b0;
		sample = '0;
		buildTable();
		tableReady = 1;
		wait (rstN === 1'b1);
		@(negedge clk);
		checkValue("busy", 0, busy);
		for (int i = 0; i < opQ.size(); i++) begin
			case (opQ[i])
				opWrite:      writeRegister(addrQ[i], dataQ[i]);
				opRead:       readRegister(addrQ[i], expectQ[i]);
				opSample:     applySample(dataQ[i], 0);
				opSampleBusy: applySample(dataQ[i], 1);
				opClear:      writeRegister(regCtrl, dataQ[i]);
				default:      ;
			endcase
		end
		checkValue("model positive saturation", 1, satHigh);
		checkValue("model negative saturation", 1, satLow);
		$display("TEST PASS");
		$finish;
	end

	// worst case per entry is well under 8 clocks
	initial begin
		wait (tableReady);
		repeat (opQ.size() * 8 + 20) @(posedge clk);
		$display("timeout: the stimulus table did not finish in time");
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- flist.f
common/notchPkg.sv
biquad/tapMultiplier.sv
biquad/sampleHistory.sv
biquad/filterAccumulator.sv
verilog/filterRegs.sv
verilog/notchFilter.sv
bench/clockGen.sv
bench/notchFilterTb.sv
